//--- Bender.yml
package:
  name: ahb_lite_eic

sources:
  - hw/eic_pkg.sv
  - hw/ahb_pkg.sv
  - hw/eic_signal_detect.sv
  - hw/eic_priority.sv
  - hw/eic_core.sv
  - hw/ahb_lite_eic.sv
  - target: test
    files:
      - verification/tb_ahb_lite_eic.sv

//--- build.f
hw/eic_pkg.sv
hw/ahb_pkg.sv
hw/eic_signal_detect.sv
hw/eic_priority.sv
hw/eic_core.sv
hw/ahb_lite_eic.sv
verification/tb_ahb_lite_eic.sv

//--- hw/ahb_lite_eic.sv
// AHB-Lite slave and top level of the external interrupt controller.
// Zero wait states, word accesses only; reads return data in the data
// phase and writes take HWDATA during the data phase.

`timescale 1ns/1ps

module ahb_lite_eic
    import ahb_pkg::*;
    import eic_pkg::*;
#(
    parameter int EIC_CHANNELS = 8
) (
    input  logic                    HCLK,
    input  logic                    HRESETn,
    input  logic [31:0]             HADDR,
    input  htrans_e                 HTRANS,
    input  logic                    HSEL,
    input  hsize_e                  HSIZE,
    input  logic                    HWRITE,
    input  logic [31:0]             HWDATA,
    output logic [31:0]             HRDATA,
    output logic                    HREADY,
    output logic                    HRESP,
    input  logic [EIC_CHANNELS-1:0] signal,
    output logic [17:1]             EIC_Offset,
    output logic [3:0]              EIC_ShadowSet,
    output logic [7:0]              EIC_Interrupt,
    output logic [5:0]              EIC_Vector,
    output logic                    EIC_Present
);

    logic        xfer_active;
    logic        xfer_write;
    eic_reg_e    read_addr;
    logic [31:0] read_data;
    eic_reg_e    write_addr;
    logic        write_enable;

    assign HREADY = 1'b1;
    assign HRESP  = 1'b0;

    assign xfer_active = HSEL && (HTRANS != IDLE);
    assign xfer_write  = xfer_active && HWRITE;

    // Address phase word address goes straight to the read mux.
    assign read_addr = eic_reg_e'(HADDR[EIC_ADDR_WIDTH+1:2]);

    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            write_enable <= 1'b0;
            HRDATA       <= '0;
        end else begin
            write_enable <= xfer_write;
            if (xfer_active && !HWRITE) begin
                HRDATA <= read_data;
            end
        end
    end

    // Held for the data phase of a write.
    always_ff @(posedge HCLK) begin
        if (xfer_write) begin
            write_addr <= read_addr;
        end
    end

    eic_core #(
        .EIC_CHANNELS (EIC_CHANNELS)
    ) i_core (
        .clk           (HCLK),
        .rst_n         (HRESETn),
        .signal        (signal),
        .read_addr     (read_addr),
        .read_data     (read_data),
        .write_addr    (write_addr),
        .write_data    (HWDATA),
        .write_enable  (write_enable),
        .EIC_Offset    (EIC_Offset),
        .EIC_ShadowSet (EIC_ShadowSet),
        .EIC_Interrupt (EIC_Interrupt),
        .EIC_Vector    (EIC_Vector),
        .EIC_Present   (EIC_Present)
    );

    a_word_access: assert property (@(posedge HCLK) disable iff (!HRESETn)
        xfer_active |-> HSIZE == WORD)
        else $error("non-word AHB access, HSIZE %0d", HSIZE);

endmodule

//--- hw/ahb_pkg.sv
// AHB-Lite transfer type and size encodings.
// Used by the bus slave to decode address phases.

package ahb_pkg;

    // HTRANS encoding.
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_e;

    // HSIZE encoding, only the sizes up to one word.
    typedef enum logic [2:0] {
        BYTE = 3'b000,
        HALF = 3'b001,
        WORD = 3'b010
    } hsize_e;

endpackage

//--- hw/eic_core.sv
// Register file and pending logic of the external interrupt controller.
// Takes decoded word reads and writes from the bus wrapper, qualifies the
// interrupt lines through the signal detector and registers the winning
// channel onto the MIPS EIC interface.

`timescale 1ns/1ps

module eic_core
    import eic_pkg::*;
#(
    parameter int EIC_CHANNELS = 8
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [EIC_CHANNELS-1:0] signal,
    input  eic_reg_e                read_addr,
    output logic [31:0]             read_data,
    input  eic_reg_e                write_addr,
    input  logic [31:0]             write_data,
    input  logic                    write_enable,
    output logic [17:1]             EIC_Offset,
    output logic [3:0]              EIC_ShadowSet,
    output logic [7:0]              EIC_Interrupt,
    output logic [5:0]              EIC_Vector,
    output logic                    EIC_Present
);

    if (EIC_CHANNELS < 1 || EIC_CHANNELS > EIC_MAX_CHANNELS) begin : g_bad_channels
        $error("EIC_CHANNELS must be in 1..%0d", EIC_MAX_CHANNELS);
    end

    // Software visible state.
    logic                      enable;
    logic [EIC_CHANNELS-1:0]   mask;
    logic [2*EIC_CHANNELS-1:0] sense;
    logic [EIC_CHANNELS-1:0]   pending;

    logic [EIC_CHANNELS-1:0]   level;
    logic [EIC_CHANNELS-1:0]   events;
    logic [EIC_CHANNELS-1:0]   set_bits;
    logic [EIC_CHANNELS-1:0]   clr_bits;
    logic [EIC_CHANNELS-1:0]   request;
    logic                      active;
    logic [5:0]                channel;

    eic_signal_detect #(
        .EIC_CHANNELS (EIC_CHANNELS)
    ) i_detect (
        .clk    (clk),
        .rst_n  (rst_n),
        .signal (signal),
        .sense  (sense),
        .level  (level),
        .events (events)
    );

    // Software set and clear strobes for the pending flags.
    assign set_bits = (write_enable && write_addr == REG_EIFR_SET) ?
                      write_data[EIC_CHANNELS-1:0] : '0;
    assign clr_bits = (write_enable && write_addr == REG_EIFR_CLR) ?
                      write_data[EIC_CHANNELS-1:0] : '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            enable <= 1'b0;
            mask   <= '0;
            sense  <= '0;
        end else if (write_enable) begin
            case (write_addr)
                REG_EICR:   enable <= write_data[0];
                REG_EIMSK:  mask   <= write_data[EIC_CHANNELS-1:0];
                REG_EISENS: sense  <= write_data[2*EIC_CHANNELS-1:0];
                default:    ;
            endcase
        end
    end

    // Level channels mirror the line, edge channels latch until cleared.
    // A set in the same cycle as a clear keeps the bit.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending <= '0;
        end else begin
            for (int i = 0; i < EIC_CHANNELS; i++) begin
                if (eic_sense_e'(sense[2*i +: 2]) == SENSE_LEVEL) begin
                    pending[i] <= level[i];
                end else begin
                    pending[i] <= events[i] | set_bits[i] | (pending[i] & ~clr_bits[i]);
                end
            end
        end
    end

    always_comb begin
        case (read_addr)
            REG_EICR:   read_data = {31'b0, enable};
            REG_EIMSK:  read_data = 32'(mask);
            REG_EIFR:   read_data = 32'(pending);
            REG_EISENS: read_data = 32'(sense);
            default:    read_data = '0;
        endcase
    end

    assign request = pending & mask & {EIC_CHANNELS{enable}};

    eic_priority #(
        .EIC_CHANNELS (EIC_CHANNELS)
    ) i_priority (
        .request (request),
        .active  (active),
        .channel (channel)
    );

    // Interrupt number is one based, zero means no request.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            EIC_Interrupt <= '0;
            EIC_Vector    <= '0;
        end else begin
            EIC_Interrupt <= active ? {2'b00, channel} + 8'd1 : 8'd0;
            EIC_Vector    <= active ? channel : 6'd0;
        end
    end

    // No shadow sets and no vector offset.
    assign EIC_Offset    = '0;
    assign EIC_ShadowSet = '0;
    assign EIC_Present   = 1'b1;

    a_irq_was_unmasked: assert property (@(posedge clk) disable iff (!rst_n)
        (EIC_Interrupt != 8'd0) |-> (($past(mask) >> (EIC_Interrupt - 8'd1)) & 1'b1) != 0)
        else $error("EIC_Interrupt %0d names a masked channel", EIC_Interrupt);

endmodule

//--- hw/eic_pkg.sv
// Register map and sense-mode encoding of the external interrupt controller.
// Imported by the core, the signal detector and the AHB-Lite wrapper.

package eic_pkg;

    // Two sense bits per channel must fit in one 32-bit register.
    localparam int EIC_MAX_CHANNELS = 16;

    // Word address width of the register map.
    localparam int EIC_ADDR_WIDTH = 3;

    // Register word addresses.
    typedef enum logic [EIC_ADDR_WIDTH-1:0] {
        // Control, bit 0 is the global enable.
        REG_EICR     = 3'd0,
        // Channel mask, 1 enables the channel.
        REG_EIMSK    = 3'd1,
        // Pending flags, read only.
        REG_EIFR     = 3'd2,
        // Write 1s to set edge pending bits.
        REG_EIFR_SET = 3'd3,
        // Write 1s to clear edge pending bits.
        REG_EIFR_CLR = 3'd4,
        // Two sense bits per channel.
        REG_EISENS   = 3'd5
    } eic_reg_e;

    // Per-channel sense mode.
    typedef enum logic [1:0] {
        // Pending follows the line.
        SENSE_LEVEL = 2'd0,
        // Low to high transition.
        SENSE_RISE  = 2'd1,
        // High to low transition.
        SENSE_FALL  = 2'd2,
        // Any transition.
        SENSE_BOTH  = 2'd3
    } eic_sense_e;

endpackage

//--- hw/eic_priority.sv
// Fixed-order priority encoder for the interrupt controller.
// The highest-numbered asserted request wins; the result is combinational
// and gets registered by the core.

`timescale 1ns/1ps

module eic_priority #(
    parameter int EIC_CHANNELS = 8
) (
    input  logic [EIC_CHANNELS-1:0] request,
    output logic                    active,
    output logic [5:0]              channel
);

    // Scan upwards so that the last hit is the highest channel.
    always_comb begin
        active  = 1'b0;
        channel = '0;
        for (int i = 0; i < EIC_CHANNELS; i++) begin
            if (request[i]) begin
                active  = 1'b1;
                channel = 6'(i);
            end
        end
    end

    // The index handed to the core must be the highest live request.
    a_channel_requested: assert final (active ? (request >> channel) == 1
                                              : request == '0)
        else $error("priority picked channel %0d for requests %b", channel, request);

endmodule

//--- hw/eic_signal_detect.sv
// Synchronizes the external interrupt lines to the clock and turns them into
// a level vector and single-cycle event pulses according to each channel's
// sense mode. Both outputs lag the input pins by three clock edges.

`timescale 1ns/1ps

module eic_signal_detect
    import eic_pkg::*;
#(
    parameter int EIC_CHANNELS = 8
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [EIC_CHANNELS-1:0]   signal,
    input  logic [2*EIC_CHANNELS-1:0] sense,
    output logic [EIC_CHANNELS-1:0]   level,
    output logic [EIC_CHANNELS-1:0]   events
);

    // Two-stage synchronizer.
    logic [EIC_CHANNELS-1:0] sync_a;
    logic [EIC_CHANNELS-1:0] sync_b;

    // Transitions between the synchronized value and the history stage.
    logic [EIC_CHANNELS-1:0] rise;
    logic [EIC_CHANNELS-1:0] fall;

    // The level register doubles as the history stage.
    assign rise = sync_b & ~level;
    assign fall = ~sync_b & level;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sync_a <= '0;
            sync_b <= '0;
            level  <= '0;
            events <= '0;
        end else begin
            sync_a <= signal;
            sync_b <= sync_a;
            level  <= sync_b;
            for (int i = 0; i < EIC_CHANNELS; i++) begin
                case (eic_sense_e'(sense[2*i +: 2]))
                    SENSE_RISE: begin
                        events[i] <= rise[i];
                    end
                    SENSE_FALL: begin
                        events[i] <= fall[i];
                    end
                    SENSE_BOTH: begin
                        events[i] <= rise[i] | fall[i];
                    end
                    // Level channels never pulse.
                    default: begin
                        events[i] <= 1'b0;
                    end
                endcase
            end
        end
    end

endmodule

//--- verification/eic_golden.txt
# op  a  b  label, numbers in hex. W addr data | R addr expected | S lines 0
# D cycles 0 | E interrupt vector. Channels 0 and 7 level, 1/4 rise, 2/5 fall, 3/6 both.
R 0 00000000 rst_eicr
R 1 00000000 rst_eimsk
R 2 00000000 rst_eifr
R 3 00000000 rst_eifr_set
R 4 00000000 rst_eifr_clr
R 5 00000000 rst_eisens
R 6 00000000 rst_unused6
R 7 00000000 rst_unused7
E 0 0 rst_outputs
W 1 ffffffff wr_mask_all
R 1 000000ff rd_mask_all
W 0 ffffffff wr_ctrl_all
R 0 00000001 rd_ctrl_all
W 5 ffffffff wr_sens_all
R 5 0000ffff rd_sens_all
R 3 00000000 rd_eifr_set
R 4 00000000 rd_eifr_clr
W 5 000039e4 wr_sens_mix
R 5 000039e4 rd_sens_mix
S ff 0 lines_rise
D 8 0 wait_rise
R 2 000000db rd_rise
E 8 7 irq_rise
S 00 0 lines_fall
D 8 0 wait_fall
R 2 0000007e rd_fall
E 7 6 irq_fall
W 4 000000ff clr_all_a
D 6 0 wait_clr_a
R 2 00000000 rd_clr_a
E 0 0 irq_clr_a
S 80 0 lines_level_hi
D 8 0 wait_level_hi
R 2 00000080 rd_level_hi
E 8 7 irq_level_hi
S 00 0 lines_level_lo
D 8 0 wait_level_lo
R 2 00000000 rd_level_lo
E 0 0 irq_level_lo
S ff 0 lines_rise_b
D 8 0 wait_rise_b
W 4 000000ff clr_edges
R 2 00000081 rd_level_kept
S 00 0 lines_fall_b
D 8 0 wait_fall_b
R 2 0000006c rd_fall_only
E 7 6 irq_prio_top
W 1 000000bf mask_ch6
D 6 0 wait_mask_ch6
E 6 5 irq_mask_ch6
W 1 0000009f mask_ch5
D 6 0 wait_mask_ch5
E 4 3 irq_mask_ch5
W 0 00000000 ctrl_disable
D 6 0 wait_disable
E 0 0 irq_disabled
W 0 00000001 ctrl_enable
D 6 0 wait_enable
E 4 3 irq_enabled
W 1 000000ff mask_restore
D 6 0 wait_restore
E 7 6 irq_unmasked
W 4 000000ff clr_all_b
D 6 0 wait_clr_b
E 0 0 irq_clr_b
W 3 00000010 sw_set_ch4
D 6 0 wait_sw_ch4
E 5 4 irq_sw_ch4
W 3 00000002 sw_set_ch1
D 6 0 wait_sw_ch1
E 5 4 irq_sw_both
R 2 00000012 rd_sw_pending
W 4 00000010 sw_clr_ch4
D 6 0 wait_clr_ch4
E 2 1 irq_sw_ch1
W 4 00000002 sw_clr_ch1
D 6 0 wait_clr_ch1
E 0 0 irq_sw_none
R 2 00000000 rd_sw_none

//--- verification/tb_ahb_lite_eic.sv
// Testbench for the AHB-Lite external interrupt controller.
// Replays the command list in the golden file against the DUT: bus writes,
// bus reads with expected data, interrupt line patterns, waits and expected
// EIC outputs. Stops at the first mismatch.

`timescale 1ns/1ps

module tb_ahb_lite_eic
    import ahb_pkg::*;
#(
    parameter int CHANNELS = 8
);

    localparam int    MAX_CMDS    = 128;
    localparam string GOLDEN_FILE = "verification/eic_golden.txt";

    logic                HCLK = 1'b0;
    logic                HRESETn;
    logic [31:0]         HADDR;
    htrans_e             HTRANS;
    logic                HSEL;
    hsize_e              HSIZE;
    logic                HWRITE;
    logic [31:0]         HWDATA;
    logic [31:0]         HRDATA;
    logic                HREADY;
    logic                HRESP;
    logic [CHANNELS-1:0] irq_lines;
    logic [17:1]         EIC_Offset;
    logic [3:0]          EIC_ShadowSet;
    logic [7:0]          EIC_Interrupt;
    logic [5:0]          EIC_Vector;
    logic                EIC_Present;

    // Command list read from the golden file.
    logic [31:0]     cmd_op    [MAX_CMDS];
    logic [31:0]     cmd_a     [MAX_CMDS];
    logic [31:0]     cmd_b     [MAX_CMDS];
    logic [8*20-1:0] cmd_label [MAX_CMDS];
    int              cmd_count   = 0;
    int              wait_total  = 0;
    int              cycle_limit = 0;
    int              cycle_count = 0;
    logic            limit_ready = 1'b0;

    ahb_lite_eic #(
        .EIC_CHANNELS (CHANNELS)
    ) i_dut (
        .HCLK          (HCLK),
        .HRESETn       (HRESETn),
        .HADDR         (HADDR),
        .HTRANS        (HTRANS),
        .HSEL          (HSEL),
        .HSIZE         (HSIZE),
        .HWRITE        (HWRITE),
        .HWDATA        (HWDATA),
        .HRDATA        (HRDATA),
        .HREADY        (HREADY),
        .HRESP         (HRESP),
        .signal        (irq_lines),
        .EIC_Offset    (EIC_Offset),
        .EIC_ShadowSet (EIC_ShadowSet),
        .EIC_Interrupt (EIC_Interrupt),
        .EIC_Vector    (EIC_Vector),
        .EIC_Present   (EIC_Present)
    );

    always #20 HCLK = ~HCLK;

    task automatic abort_run();
        $display("test failed");
        $fatal(1, "Stopping after the first error.");
    endtask

    task automatic check_value(input logic [8*20-1:0] label, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("CHECK FAILED %0s: expected %08h, actual %08h", label, expected, actual);
            abort_run();
        end
    endtask

    // Run length guard, armed once the command list is known.
    always @(posedge HCLK) begin
        cycle_count = cycle_count + 1;
        if (limit_ready && cycle_count > cycle_limit) begin
            $display("Timeout: the run took more than %0d cycles.", cycle_limit);
            abort_run();
        end
    end

    task automatic load_golden();
        int              fd;
        int              fields;
        string           line;
        logic [31:0]     op;
        logic [31:0]     a;
        logic [31:0]     b;
        logic [8*20-1:0] label;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the golden file %0s.", GOLDEN_FILE);
            abort_run();
        end
        while (!$feof(fd)) begin
            fields = $fgets(line, fd);
            // Skip comments and blank lines.
            if (fields != 0 && line.len() > 1 && line.getc(0) != "#") begin
                fields = $sscanf(line, "%s %h %h %s", op, a, b, label);
                if (fields == 4) begin
                    if (cmd_count == MAX_CMDS) begin
                        $display("The golden file holds more than %0d commands.", MAX_CMDS);
                        abort_run();
                    end
                    cmd_op[cmd_count]    = op;
                    cmd_a[cmd_count]     = a;
                    cmd_b[cmd_count]     = b;
                    cmd_label[cmd_count] = label;
                    if (op == "D") begin
                        wait_total = wait_total + int'(a);
                    end
                    cmd_count = cmd_count + 1;
                end
            end
        end
        $fclose(fd);
        cycle_limit = wait_total + 4 * cmd_count + 50;
        limit_ready = 1'b1;
    endtask

    // Address phase, data phase, then one idle cycle.
    task automatic bus_write(input logic [2:0] addr, input logic [31:0] data);
        @(negedge HCLK);
        HSEL   = 1'b1;
        HTRANS = NONSEQ;
        HWRITE = 1'b1;
        HADDR  = {27'b0, addr, 2'b00};
        @(negedge HCLK);
        HSEL   = 1'b0;
        HTRANS = IDLE;
        HWRITE = 1'b0;
        HWDATA = data;
        @(negedge HCLK);
    endtask

    // HRDATA is sampled in the middle of the data phase.
    task automatic bus_read(input logic [2:0] addr, input logic [31:0] expected,
                            input logic [8*20-1:0] label);
        @(negedge HCLK);
        HSEL   = 1'b1;
        HTRANS = NONSEQ;
        HWRITE = 1'b0;
        HADDR  = {27'b0, addr, 2'b00};
        @(negedge HCLK);
        HSEL   = 1'b0;
        HTRANS = IDLE;
        check_value(label, expected, HRDATA);
    endtask

    task automatic run_command(input int idx);
        case (cmd_op[idx])
            "W": bus_write(cmd_a[idx][2:0], cmd_b[idx]);
            "R": bus_read(cmd_a[idx][2:0], cmd_b[idx], cmd_label[idx]);
            "S": begin
                @(negedge HCLK);
                irq_lines = cmd_a[idx][CHANNELS-1:0];
            end
            "D": repeat (cmd_a[idx]) @(negedge HCLK);
            "E": begin
                @(negedge HCLK);
                check_value(cmd_label[idx], cmd_a[idx], {24'b0, EIC_Interrupt});
                check_value(cmd_label[idx], cmd_b[idx], {26'b0, EIC_Vector});
            end
            default: begin
                $display("Unknown command on golden line %0d: %0s.", idx, cmd_label[idx]);
                abort_run();
            end
        endcase
    endtask

    initial begin
        HRESETn   = 1'b0;
        HADDR     = '0;
        HTRANS    = IDLE;
        HSEL      = 1'b0;
        HSIZE     = WORD;
        HWRITE    = 1'b0;
        HWDATA    = '0;
        irq_lines = '0;
        load_golden();
        repeat (3) @(negedge HCLK);
        HRESETn = 1'b1;
        // Outputs tied off by the design.
        check_value("rst_hready", 32'd1, {31'b0, HREADY});
        check_value("rst_hresp", 32'd0, {31'b0, HRESP});
        check_value("rst_present", 32'd1, {31'b0, EIC_Present});
        check_value("rst_offset", 32'd0, {15'b0, EIC_Offset});
        check_value("rst_shadowset", 32'd0, {28'b0, EIC_ShadowSet});
        for (int i = 0; i < cmd_count; i++) begin
            run_command(i);
        end
        $display("test passed");
        $finish;
    end

endmodule
